// ==== common/icache_pkg.sv ====
package icache_pkg;

    // fetch address and instruction word
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned WORD_W = 32;

    // byte offset inside one word
    localparam int unsigned BYTE_OFF_W = 2;

    // the stored tag is the page number
    // sets * line bytes must stay within one 4 KiB page
    localparam int unsigned TAG_LSB = 12;
    localparam int unsigned TAG_W = ADDR_W - TAG_LSB;

    // addresses with this bit set bypass the cache
    localparam int unsigned UNCACHED_BIT = 31;

    // one tag RAM entry
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

// ==== src/cache_ram.sv ====
module cache_ram #(
    parameter type         entry_t = logic [31:0],
    parameter int unsigned DEPTH   = 16
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic                     we_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem [DEPTH];

    // one access per cycle, a write shows its new value on the read port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
            rdata_o     <= wdata_i;
        end else begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// ==== icache/refill_counter.sv ====
module refill_counter #(
    parameter int unsigned CNT_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear_i,
    input  logic             step_i,
    input  logic [CNT_W-1:0] limit_i,
    output logic [CNT_W-1:0] count_o,
    output logic             last_o
);

    // final step of the current walk
    assign last_o = (count_o == limit_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else if (step_i) begin
            // wrap so the next walk starts from zero
            if (last_o) begin
                count_o <= '0;
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule

// ==== icache/way_lookup.sv ====
module way_lookup #(
    parameter int unsigned SET_NUM = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [$clog2(SET_NUM)-1:0]    set_i,
    input  logic [icache_pkg::TAG_W-1:0]  tag_i,
    input  icache_pkg::tag_entry_t        tag0_i,
    input  icache_pkg::tag_entry_t        tag1_i,
    input  logic [icache_pkg::WORD_W-1:0] data0_i,
    input  logic [icache_pkg::WORD_W-1:0] data1_i,
    input  logic                          update_i,
    output logic                          hit_o,
    output logic [icache_pkg::WORD_W-1:0] data_o,
    output logic                          victim_o
);

    import icache_pkg::*;

    logic               hit0;
    logic               hit1;
    logic [SET_NUM-1:0] repl_q;

    // a way hits only with a valid matching entry
    assign hit0 = tag0_i.valid && (tag0_i.tag == tag_i);
    assign hit1 = tag1_i.valid && (tag1_i.tag == tag_i);

    assign hit_o  = hit0 | hit1;
    assign data_o = hit0 ? data0_i : data1_i;

    // one bit per set, points at the next way to refill
    assign victim_o = repl_q[set_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            repl_q <= '0;
        end else if (update_i) begin
            repl_q[set_i] <= ~repl_q[set_i];
        end
    end

endmodule

// ==== icache/icache_ctrl.sv ====
module icache_ctrl #(
    parameter int unsigned SET_NUM    = 16,
    parameter int unsigned LINE_WORDS = 4,
    parameter int unsigned CNT_W      = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic                          fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic                          fetch_ack_o,
    output logic [icache_pkg::WORD_W-1:0] fetch_data_o,
    output logic                          mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic                          mem_ack_i,
    input  logic [icache_pkg::WORD_W-1:0] mem_data_i,
    output logic [$clog2(SET_NUM)-1:0]    ram_set_o,
    output logic [$clog2(LINE_WORDS)-1:0] ram_word_o,
    output logic [1:0]                    tag_we_o,
    output logic [1:0]                    data_we_o,
    output icache_pkg::tag_entry_t        tag_wdata_o,
    output logic [icache_pkg::WORD_W-1:0] data_wdata_o,
    output logic                          cnt_clear_o,
    output logic                          cnt_step_o,
    output logic [CNT_W-1:0]              cnt_limit_o,
    input  logic [CNT_W-1:0]              cnt_count_i,
    input  logic                          cnt_last_i,
    input  logic                          hit_i,
    input  logic [icache_pkg::WORD_W-1:0] hit_data_i,
    input  logic                          victim_i,
    output logic                          replace_o
);

    import icache_pkg::*;

    localparam int unsigned SET_W   = $clog2(SET_NUM);
    localparam int unsigned OFF_W   = $clog2(LINE_WORDS);
    localparam int unsigned SET_LSB = BYTE_OFF_W + OFF_W;

    typedef enum logic [3:0] {
        S_SWEEP,
        S_IDLE,
        S_LOOKUP,
        S_COMPARE,
        S_REFILL_REQ,
        S_REFILL_WAIT,
        S_UNC_REQ,
        S_UNC_WAIT,
        S_ACK
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] data_q;
    logic [SET_W-1:0]  req_set;
    logic [OFF_W-1:0]  req_word;
    logic [1:0]        victim_way;
    logic              fetch_take;
    logic              in_refill;

    assign req_set    = addr_q[SET_LSB +: SET_W];
    assign req_word   = addr_q[BYTE_OFF_W +: OFF_W];
    assign victim_way = victim_i ? 2'b10 : 2'b01;
    assign in_refill  = (state_q == S_REFILL_REQ) || (state_q == S_REFILL_WAIT);

    // flush wins over a fetch raised in the same cycle
    assign fetch_take = (state_q == S_IDLE) && !flush_i && fetch_req_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_SWEEP;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_take) begin
            addr_q <= fetch_addr_i;
        end
        // hit word or bypass word, held through the ack phase
        if (state_q == S_COMPARE && hit_i) begin
            data_q <= hit_data_i;
        end else if (state_q == S_UNC_REQ && mem_ack_i) begin
            data_q <= mem_data_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_SWEEP: begin
                if (cnt_last_i) begin
                    state_d = S_IDLE;
                end
            end
            S_IDLE: begin
                if (flush_i) begin
                    state_d = S_SWEEP;
                end else if (fetch_req_i) begin
                    state_d = fetch_addr_i[UNCACHED_BIT] ? S_UNC_REQ : S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_d = S_COMPARE;
            end
            S_COMPARE: begin
                state_d = hit_i ? S_ACK : S_REFILL_REQ;
            end
            S_REFILL_REQ: begin
                if (mem_ack_i) begin
                    state_d = S_REFILL_WAIT;
                end
            end
            S_REFILL_WAIT: begin
                // after the last word look up again, which now hits
                if (!mem_ack_i) begin
                    state_d = cnt_last_i ? S_LOOKUP : S_REFILL_REQ;
                end
            end
            S_UNC_REQ: begin
                if (mem_ack_i) begin
                    state_d = S_UNC_WAIT;
                end
            end
            S_UNC_WAIT: begin
                if (!mem_ack_i) begin
                    state_d = S_ACK;
                end
            end
            S_ACK: begin
                if (!fetch_req_i) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    // counter walks sets in the sweep and words in a refill
    assign cnt_clear_o = (state_q == S_IDLE && flush_i) || (state_q == S_COMPARE && !hit_i);
    assign cnt_step_o  = (state_q == S_SWEEP) || (state_q == S_REFILL_WAIT && !mem_ack_i);
    assign cnt_limit_o = (state_q == S_SWEEP) ? CNT_W'(SET_NUM - 1) : CNT_W'(LINE_WORDS - 1);
    assign replace_o   = (state_q == S_REFILL_WAIT) && !mem_ack_i && cnt_last_i;

    always_comb begin
        ram_set_o  = req_set;
        ram_word_o = req_word;
        if (state_q == S_SWEEP) begin
            ram_set_o = cnt_count_i[SET_W-1:0];
        end else if (in_refill) begin
            ram_word_o = cnt_count_i[OFF_W-1:0];
        end
    end

    // sweep writes invalid entries, a refill writes the valid tag
    assign tag_wdata_o.valid = (state_q != S_SWEEP);
    assign tag_wdata_o.tag   = addr_q[ADDR_W-1:TAG_LSB];
    assign data_wdata_o      = mem_data_i;

    always_comb begin
        tag_we_o  = 2'b00;
        data_we_o = 2'b00;
        if (state_q == S_SWEEP) begin
            tag_we_o = 2'b11;
        end else if (state_q == S_REFILL_REQ && mem_ack_i) begin
            data_we_o = victim_way;
            if (cnt_last_i) begin
                tag_we_o = victim_way;
            end
        end
    end

    assign mem_req_o  = (state_q == S_REFILL_REQ) || (state_q == S_UNC_REQ);
    assign mem_addr_o = in_refill ?
        {addr_q[ADDR_W-1:SET_LSB], cnt_count_i[OFF_W-1:0], {BYTE_OFF_W{1'b0}}} :
        {addr_q[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};

    assign fetch_ack_o  = (state_q == S_ACK);
    assign fetch_data_o = data_q;

endmodule

// ==== src/icache_top.sv ====
module icache_top #(
    parameter int unsigned SET_NUM    = 16,
    parameter int unsigned LINE_WORDS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic                          fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic                          fetch_ack_o,
    output logic [icache_pkg::WORD_W-1:0] fetch_data_o,
    output logic                          mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic                          mem_ack_i,
    input  logic [icache_pkg::WORD_W-1:0] mem_data_i
);

    import icache_pkg::*;

    localparam int unsigned SET_W = $clog2(SET_NUM);
    localparam int unsigned OFF_W = $clog2(LINE_WORDS);
    // wide enough for both the sweep and the refill walk
    localparam int unsigned CNT_W = (SET_W > OFF_W) ? SET_W : OFF_W;

    logic [SET_W-1:0]  ram_set;
    logic [OFF_W-1:0]  ram_word;
    logic [1:0]        tag_we;
    logic [1:0]        data_we;
    tag_entry_t        tag_wdata;
    logic [WORD_W-1:0] data_wdata;
    tag_entry_t        tag_rdata0;
    tag_entry_t        tag_rdata1;
    logic [WORD_W-1:0] data_rdata0;
    logic [WORD_W-1:0] data_rdata1;
    logic              cnt_clear;
    logic              cnt_step;
    logic [CNT_W-1:0]  cnt_limit;
    logic [CNT_W-1:0]  cnt_count;
    logic              cnt_last;
    logic              hit;
    logic [WORD_W-1:0] hit_data;
    logic              victim;
    logic              replace;

    icache_ctrl #(
        .SET_NUM   (SET_NUM),
        .LINE_WORDS(LINE_WORDS),
        .CNT_W     (CNT_W)
    ) ctrl0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .fetch_req_i (fetch_req_i),
        .fetch_addr_i(fetch_addr_i),
        .fetch_ack_o (fetch_ack_o),
        .fetch_data_o(fetch_data_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_ack_i   (mem_ack_i),
        .mem_data_i  (mem_data_i),
        .ram_set_o   (ram_set),
        .ram_word_o  (ram_word),
        .tag_we_o    (tag_we),
        .data_we_o   (data_we),
        .tag_wdata_o (tag_wdata),
        .data_wdata_o(data_wdata),
        .cnt_clear_o (cnt_clear),
        .cnt_step_o  (cnt_step),
        .cnt_limit_o (cnt_limit),
        .cnt_count_i (cnt_count),
        .cnt_last_i  (cnt_last),
        .hit_i       (hit),
        .hit_data_i  (hit_data),
        .victim_i    (victim),
        .replace_o   (replace)
    );

    refill_counter #(
        .CNT_W(CNT_W)
    ) cnt0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear_i(cnt_clear),
        .step_i (cnt_step),
        .limit_i(cnt_limit),
        .count_o(cnt_count),
        .last_o (cnt_last)
    );

    // request tag comes from the controller's tag write value
    way_lookup #(
        .SET_NUM(SET_NUM)
    ) lookup0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .set_i   (ram_set),
        .tag_i   (tag_wdata.tag),
        .tag0_i  (tag_rdata0),
        .tag1_i  (tag_rdata1),
        .data0_i (data_rdata0),
        .data1_i (data_rdata1),
        .update_i(replace),
        .hit_o   (hit),
        .data_o  (hit_data),
        .victim_o(victim)
    );

    cache_ram #(
        .entry_t(tag_entry_t),
        .DEPTH  (SET_NUM)
    ) tag_ram0 (
        .clk    (clk),
        .addr_i (ram_set),
        .we_i   (tag_we[0]),
        .wdata_i(tag_wdata),
        .rdata_o(tag_rdata0)
    );

    cache_ram #(
        .entry_t(tag_entry_t),
        .DEPTH  (SET_NUM)
    ) tag_ram1 (
        .clk    (clk),
        .addr_i (ram_set),
        .we_i   (tag_we[1]),
        .wdata_i(tag_wdata),
        .rdata_o(tag_rdata1)
    );

    // data RAMs are addressed by set and word within the line
    cache_ram #(
        .entry_t(logic [WORD_W-1:0]),
        .DEPTH  (SET_NUM * LINE_WORDS)
    ) data_ram0 (
        .clk    (clk),
        .addr_i ({ram_set, ram_word}),
        .we_i   (data_we[0]),
        .wdata_i(data_wdata),
        .rdata_o(data_rdata0)
    );

    cache_ram #(
        .entry_t(logic [WORD_W-1:0]),
        .DEPTH  (SET_NUM * LINE_WORDS)
    ) data_ram1 (
        .clk    (clk),
        .addr_i ({ram_set, ram_word}),
        .we_i   (data_we[1]),
        .wdata_i(data_wdata),
        .rdata_o(data_rdata1)
    );

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
    parameter int unsigned HALF_PERIOD = 4
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
    end

    // 8 ns period with the default half period
    always begin
        #(HALF_PERIOD);
        clk_o = ~clk_o;
    end

endmodule

// ==== tb/icache_checker.sv ====
module icache_checker #(
    parameter int unsigned SET_NUM    = 16,
    parameter int unsigned LINE_WORDS = 4,
    parameter logic [31:0] MEM_XOR    = 32'ha5a5a5a5
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic                          fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
    input  logic                          fetch_ack_i,
    input  logic [icache_pkg::WORD_W-1:0] fetch_data_i,
    input  logic                          mem_req_i,
    input  logic [icache_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic                          mem_ack_i,
    input  int                            exp_beats_i,
    output int                            errors_o,
    output int                            checks_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    localparam int unsigned SET_W      = $clog2(SET_NUM);
    localparam int unsigned LINE_BYTES = LINE_WORDS * 4;
    localparam int unsigned SET_LSB    = $clog2(LINE_BYTES);
    // first negedge with req high comes one cycle before the DUT samples it
    localparam int unsigned HIT_CYCLES = 3;

    logic              valid_m [2][SET_NUM];
    logic [TAG_W-1:0]  tag_m   [2][SET_NUM];
    logic              repl_m  [SET_NUM];
    logic              busy;
    logic              ack_q;
    logic              mem_req_q;
    logic              mem_ack_q;
    logic              uncached;
    logic              pred_hit;
    logic [ADDR_W-1:0] req_addr;
    logic [SET_W-1:0]  req_set;
    logic [TAG_W-1:0]  req_tag;
    int                cycles;
    int                beats;

    initial begin
        errors_o  = 0;
        checks_o  = 0;
        busy      = 1'b0;
        ack_q     = 1'b0;
        mem_req_q = 1'b0;
        mem_ack_q = 1'b0;
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic invalidate_model();
        for (int s = 0; s < SET_NUM; s++) begin
            valid_m[0][s] = 1'b0;
            valid_m[1][s] = 1'b0;
        end
    endtask

    task automatic start_fetch();
        busy     = 1'b1;
        cycles   = 0;
        beats    = 0;
        req_addr = fetch_addr_i;
        req_set  = fetch_addr_i[SET_LSB +: SET_W];
        req_tag  = fetch_addr_i[ADDR_W-1:TAG_LSB];
        uncached = fetch_addr_i[UNCACHED_BIT];
        pred_hit = !uncached &&
            ((valid_m[0][req_set] && tag_m[0][req_set] == req_tag) ||
             (valid_m[1][req_set] && tag_m[1][req_set] == req_tag));
    endtask

    task automatic check_beat();
        logic [ADDR_W-1:0] exp_addr;
        // refill walks the line from word 0, bypass reads only its own word
        if (uncached) begin
            exp_addr = {req_addr[ADDR_W-1:2], 2'b00};
        end else begin
            exp_addr = (req_addr & ~(LINE_BYTES - 1)) + beats * 4;
        end
        compare_value("memory address", mem_addr_i, exp_addr);
        beats++;
    endtask

    task automatic finish_fetch();
        int   model_beats;
        logic way;
        model_beats = uncached ? 1 : (pred_hit ? 0 : LINE_WORDS);
        compare_value("fetch data", fetch_data_i, {req_addr[ADDR_W-1:2], 2'b00} ^ MEM_XOR);
        compare_value("beats against table", beats, exp_beats_i);
        compare_value("beats against model", beats, model_beats);
        if (pred_hit) begin
            compare_value("hit latency", cycles, HIT_CYCLES);
        end
        // a refill fills the victim way and flips the set's bit
        if (!uncached && !pred_hit) begin
            way                   = repl_m[req_set];
            valid_m[way][req_set] = 1'b1;
            tag_m[way][req_set]   = req_tag;
            repl_m[req_set]       = !way;
        end
        busy = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            invalidate_model();
            for (int s = 0; s < SET_NUM; s++) begin
                repl_m[s] = 1'b0;
            end
            busy = 1'b0;
            if (fetch_ack_i === 1'b1 || mem_req_i === 1'b1) begin
                errors_o++;
                $display("ERROR %0t: ack or memory request active in reset", $time);
            end
        end else begin
            if (fetch_ack_i && !ack_q && !busy) begin
                errors_o++;
                $display("ERROR %0t: fetch ack rose without a request", $time);
            end
            // ack as the DUT sampled it on the edge that raised the request
            if (mem_req_i && !mem_req_q && mem_ack_q) begin
                errors_o++;
                $display("ERROR %0t: memory request rose while ack was high", $time);
            end
            // flush clears valid bits only, replacement bits stay
            if (flush_i) begin
                invalidate_model();
            end
            if (busy) begin
                cycles++;
                if (mem_req_i && !mem_req_q) begin
                    check_beat();
                end
                if (fetch_ack_i && !ack_q) begin
                    finish_fetch();
                end
            end
            if (fetch_req_i && !busy && !fetch_ack_i) begin
                start_fetch();
            end
        end
        ack_q     = fetch_ack_i;
        mem_req_q = mem_req_i;
        mem_ack_q = mem_ack_i;
    end

endmodule

// ==== tb/icache_tb.sv ====
module icache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SET_NUM     = 16;
    localparam int unsigned LINE_WORDS  = 4;
    localparam logic [31:0] MEM_XOR     = 32'ha5a5a5a5;
    localparam int          ACK_TIMEOUT = 200;
    localparam int          MAX_ROWS    = 32;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_ack;
    logic [31:0] fetch_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_data;
    int          exp_beats;
    int          chk_errors;
    int          chk_checks;
    int          timeouts;
    logic [31:0] rnd_q;

    // stimulus table: address, flush before the fetch, expected memory beats
    logic [31:0] row_addr  [MAX_ROWS];
    logic        row_flush [MAX_ROWS];
    int          row_beats [MAX_ROWS];
    int          n_rows;

    tb_clock clk0 (
        .clk_o(clk)
    );

    icache_top #(
        .SET_NUM   (SET_NUM),
        .LINE_WORDS(LINE_WORDS)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush),
        .fetch_req_i (fetch_req),
        .fetch_addr_i(fetch_addr),
        .fetch_ack_o (fetch_ack),
        .fetch_data_o(fetch_data),
        .mem_req_o   (mem_req),
        .mem_addr_o  (mem_addr),
        .mem_ack_i   (mem_ack),
        .mem_data_i  (mem_data)
    );

    icache_checker #(
        .SET_NUM   (SET_NUM),
        .LINE_WORDS(LINE_WORDS),
        .MEM_XOR   (MEM_XOR)
    ) chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush),
        .fetch_req_i (fetch_req),
        .fetch_addr_i(fetch_addr),
        .fetch_ack_i (fetch_ack),
        .fetch_data_i(fetch_data),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_ack_i   (mem_ack),
        .exp_beats_i (exp_beats),
        .errors_o    (chk_errors),
        .checks_o    (chk_checks)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic [31:0] addr, input logic flush_first, input int beats);
        row_addr[n_rows]  = addr;
        row_flush[n_rows] = flush_first;
        row_beats[n_rows] = beats;
        n_rows++;
    endtask

    // the invalidate sweep takes SET_NUM cycles
    task automatic wait_sweep();
        repeat (SET_NUM + 2) @(posedge clk);
        #1;
    endtask

    task automatic wait_fetch_ack(input logic level, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            ok = (fetch_ack === level);
            n++;
        end
    endtask

    // memory answers each request after 0 to 3 cycles
    // and may hold ack one more cycle after the request drops
    initial begin : memory_model
        int delay;
        int n;
        mem_ack  = 1'b0;
        mem_data = '0;
        rnd_q    = 32'h75dce06a;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req && !mem_ack) begin
                rnd_q = next_random(rnd_q);
                delay = rnd_q % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_data = mem_addr ^ MEM_XOR;
                mem_ack  = 1'b1;
                n        = 0;
                while (mem_req && n < ACK_TIMEOUT) begin
                    @(posedge clk);
                    #1;
                    n++;
                end
                if (mem_req) begin
                    timeouts++;
                    $display("timeout: memory request was never released");
                end
                rnd_q = next_random(rnd_q);
                delay = rnd_q % 2;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int   row;
        logic ok;
        rst_n      = 1'b0;
        flush      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        exp_beats  = 0;
        timeouts   = 0;
        n_rows     = 0;
        // set 3 is shared by tags 1, 2 and 3
        add_row(32'h0000_1030, 1'b0, 4);
        add_row(32'h0000_1034, 1'b0, 0);
        add_row(32'h0000_103c, 1'b0, 0);
        add_row(32'h0000_2030, 1'b0, 4);
        add_row(32'h0000_1038, 1'b0, 0);
        add_row(32'h0000_3030, 1'b0, 4);
        add_row(32'h0000_2034, 1'b0, 0);
        add_row(32'h0000_1030, 1'b0, 4);
        add_row(32'h0000_3038, 1'b0, 0);
        // uncached space never fills a line
        add_row(32'h8000_0040, 1'b0, 1);
        add_row(32'h8000_0040, 1'b0, 1);
        add_row(32'h8000_1030, 1'b0, 1);
        add_row(32'h0000_1034, 1'b0, 0);
        add_row(32'h0000_50f0, 1'b0, 4);
        add_row(32'h0000_50fc, 1'b0, 0);
        add_row(32'h0000_1030, 1'b1, 4);
        add_row(32'h0000_50f4, 1'b0, 4);
        add_row(32'h0000_3030, 1'b0, 4);
        add_row(32'h0000_1038, 1'b0, 0);
        add_row(32'h0000_3034, 1'b0, 0);
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_sweep();
        for (row = 0; row < n_rows && timeouts == 0; row++) begin
            if (row_flush[row]) begin
                flush = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
                wait_sweep();
            end
            exp_beats  = row_beats[row];
            fetch_addr = row_addr[row];
            fetch_req  = 1'b1;
            wait_fetch_ack(1'b1, ok);
            fetch_req = 1'b0;
            if (!ok) begin
                timeouts++;
                $display("timeout: no fetch ack for row %0d", row);
            end else begin
                wait_fetch_ack(1'b0, ok);
                if (!ok) begin
                    timeouts++;
                    $display("timeout: fetch ack stayed high after row %0d", row);
                end
            end
        end
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d, timeouts: %0d", chk_checks, chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/icache_pkg.sv
src/cache_ram.sv
icache/refill_counter.sv
icache/way_lookup.sv
icache/icache_ctrl.sv
src/icache_top.sv
tb/tb_clock.sv
tb/icache_checker.sv
tb/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - common/icache_pkg.sv
  - src/cache_ram.sv
  - icache/refill_counter.sv
  - icache/way_lookup.sv
  - icache/icache_ctrl.sv
  - src/icache_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/icache_checker.sv
      - tb/icache_tb.sv
